// File: common/hpu_pkg.sv
`default_nettype none

package hpu_pkg;

    // bus address and data width
    localparam int ADDR_W = 32;

    // message identifier width
    localparam int MSGID_W = 10;

    // home cluster is taken from the low message id bits
    localparam int NUM_CLUSTERS = 4;
    localparam int CLUSTER_W    = $clog2(NUM_CLUSTERS);

    // region select on addr[8:7]
    localparam logic [1:0] REGION_TASK = 2'd0;

    // task region word offsets, addr[7:0]
    localparam logic [7:0] REG_HANDLER_FUN  = 8'h00;
    localparam logic [7:0] REG_HANDLER_MEM  = 8'h08;
    localparam logic [7:0] REG_PKT_PTR      = 8'h10;
    localparam logic [7:0] REG_PKT_SIZE     = 8'h14;
    localparam logic [7:0] REG_PKT_ADDR     = 8'h44;
    localparam logic [7:0] REG_HOME_CLUSTER = 8'h48;
    localparam logic [7:0] REG_MSGID        = 8'h4C;
    // termination word, reads as zero
    localparam logic [7:0] REG_FEEDBACK     = 8'h50;

    // handler task as handed over by the scheduler
    typedef struct packed {
        logic [ADDR_W-1:0]  handler_fun;
        logic [ADDR_W-1:0]  handler_mem;
        logic [ADDR_W-1:0]  pkt_ptr;
        logic [ADDR_W-1:0]  pkt_addr;
        logic [ADDR_W-1:0]  pkt_size;
        logic [MSGID_W-1:0] msgid;
    } hpu_task_t;

    // descriptor returned once the handler terminates
    typedef struct packed {
        logic [ADDR_W-1:0]  pkt_ptr;
        logic [ADDR_W-1:0]  pkt_addr;
        logic [ADDR_W-1:0]  pkt_size;
        logic [MSGID_W-1:0] msgid;
    } feedback_t;

    // controller states
    typedef enum logic [1:0] {
        Init,
        Idle,
        Running,
        SendingFeedback
    } hpu_state_t;

endpackage

`default_nettype wire

// File: common/periph_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

interface periph_bus_if import hpu_pkg::*; ();

    // core side
    logic              req;
    logic [ADDR_W-1:0] addr;
    logic              wen_n;
    logic [ADDR_W-1:0] wdata;

    // driver side
    logic              gnt;
    logic              rvalid;
    logic [ADDR_W-1:0] rdata;

    modport core (
        output req, addr, wen_n, wdata,
        input  gnt, rvalid, rdata
    );

    modport driver (
        input  req, addr, wen_n, wdata,
        output gnt, rvalid, rdata
    );

endinterface

`default_nettype wire

// File: hpu_ctrl/hpu_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module hpu_ctrl import hpu_pkg::*; (
    input  wire logic              clk_i,
    input  wire logic              rst_ni,

    periph_bus_if.driver           bus_i,

    // task handshake
    input  wire logic              task_valid_i,
    output logic                   task_ready_o,
    input  wire logic [ADDR_W-1:0] handler_fun_i,
    output logic                   capture_o,

    // feedback buffer control
    input  wire logic              fb_full_i,
    output logic                   fb_push_o,

    output logic                   active_o
);

    hpu_state_t state_d, state_q;

    logic task_req;
    logic term_hit;
    logic trigger_feedback;

    // only region 0 is served, the rest stays unanswered
    assign task_req = bus_i.req && (bus_i.addr[8:7] == REGION_TASK);
    assign term_hit = (bus_i.addr[7:0] == REG_FEEDBACK);

    // grant task words only while a handler runs
    assign bus_i.gnt = (state_q == Running) && task_req;

    // read or write of the termination word ends the handler
    assign trigger_feedback = bus_i.gnt && term_hit;

    assign task_ready_o = (state_q == Idle);
    assign active_o     = (state_q != Init);
    assign capture_o    = task_valid_i && task_ready_o;

    assign fb_push_o = !fb_full_i &&
                       (trigger_feedback || (state_q == SendingFeedback));

    always_comb begin
        state_d = state_q;

        case (state_q)
            Init: begin
                // first access from the core means its runtime is up
                if (task_req) begin
                    state_d = Idle;
                end
            end

            Idle: begin
                if (capture_o) begin
                    // no handler, feedback goes out straight away
                    if (handler_fun_i == '0) begin
                        state_d = SendingFeedback;
                    end else begin
                        state_d = Running;
                    end
                end
            end

            Running: begin
                if (trigger_feedback) begin
                    state_d = fb_full_i ? SendingFeedback : Idle;
                end
            end

            SendingFeedback: begin
                // wait for the previous descriptor to drain
                if (!fb_full_i) begin
                    state_d = Idle;
                end
            end

            default: begin
                state_d = Idle;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= Init;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

`default_nettype wire

// File: sim/hpu_driver_sva.sv
`timescale 1ns/1ps
`default_nettype none

module hpu_driver_sva import hpu_pkg::*; (
    input wire logic      clk_i,
    input wire logic      rst_ni,
    input wire logic      req_i,
    input wire logic      gnt_i,
    input wire logic      rvalid_i,
    input wire logic      fb_valid_i,
    input wire logic      fb_ready_i,
    input wire logic      no_dma_i,
    input wire feedback_t fb_data_i
);

    gnt_needs_req: assert property (@(posedge clk_i) disable iff (!rst_ni) gnt_i |-> req_i)
        else $error("bus grant without a request");

    // one response per grant, one cycle later
    rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
        rvalid_i == $past(gnt_i))
        else $error("bus rvalid not exactly one cycle after grant");

    fb_valid_gated: assert property (@(posedge clk_i) disable iff (!rst_ni)
        fb_valid_i |-> no_dma_i)
        else $error("feedback valid while a dma request is pending");

    fb_data_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (fb_valid_i && !fb_ready_i) |=> $stable(fb_data_i))
        else $error("feedback data changed before it was taken");

endmodule

bind hpu_driver hpu_driver_sva i_hpu_driver_sva (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req_i      (bus_req_i),
    .gnt_i      (bus_gnt_o),
    .rvalid_i   (bus_rvalid_o),
    .fb_valid_i (hpu_feedback_valid_o),
    .fb_ready_i (hpu_feedback_ready_i),
    .no_dma_i   (no_dma_req_pending_i),
    .fb_data_i  (hpu_feedback_o)
);

`default_nettype wire

// File: sim/tb_hpu_driver.sv
`timescale 1ns/1ps
`default_nettype none

module tb_hpu_driver import hpu_pkg::*; ();

    localparam int NUM_TASKS  = 40;
    localparam int MAX_CYCLES = 4000;

    logic              clk_i;
    logic              rst_ni;
    logic [5:0]        cluster_id_i;
    logic              hpu_task_valid_i;
    logic              hpu_task_ready_o;
    hpu_task_t         hpu_task_i;
    logic              hpu_feedback_valid_o;
    logic              hpu_feedback_ready_i;
    feedback_t         hpu_feedback_o;
    logic              hpu_active_o;
    logic              no_dma_req_pending_i;
    logic              bus_req_i;
    logic [ADDR_W-1:0] bus_addr_i;
    logic              bus_wen_ni;
    logic [ADDR_W-1:0] bus_wdata_i;
    logic              bus_gnt_o;
    logic              bus_rvalid_o;
    logic [ADDR_W-1:0] bus_rdata_o;

    // reference model
    hpu_task_t         cur_task = '0;
    feedback_t         fb_queue[$];
    logic              running = 1'b0;
    logic              init_done = 1'b0;
    logic              gnt_q = 1'b0;
    logic [ADDR_W-1:0] word_q = '0;

    integer seed = 32'hc459;
    int     err_value = 0;
    int     err_other = 0;
    int     cycles = 0;
    int     pops = 0;

    // mapped offsets followed by a few unmapped ones
    logic [7:0] offsets [10] = '{REG_HANDLER_FUN, REG_HANDLER_MEM, REG_PKT_PTR, REG_PKT_SIZE,
                                 REG_PKT_ADDR, REG_HOME_CLUSTER, REG_MSGID, 8'h04, 8'h20, 8'h7C};

    hpu_driver dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    always @(posedge clk_i) cycles <= cycles + 1;

    function automatic logic [ADDR_W-1:0] map_word(input hpu_task_t t, input logic [7:0] off);
        case (off)
            REG_HANDLER_FUN:  return t.handler_fun;
            REG_HANDLER_MEM:  return t.handler_mem;
            REG_PKT_PTR:      return t.pkt_ptr;
            REG_PKT_SIZE:     return t.pkt_size;
            REG_PKT_ADDR:     return t.pkt_addr;
            REG_HOME_CLUSTER: return ADDR_W'(t.msgid % NUM_CLUSTERS);
            REG_MSGID:        return ADDR_W'(t.msgid);
            default:          return '0;
        endcase
    endfunction

    function automatic feedback_t expected_feedback(input hpu_task_t t);
        return '{pkt_ptr: t.pkt_ptr, pkt_addr: t.pkt_addr, pkt_size: t.pkt_size, msgid: t.msgid};
    endfunction

    task automatic report_mismatch(input string name, input logic [127:0] got, exp);
        err_value++;
        $display("Error: %s got %0h expected %0h", name, got, exp);
    endtask

    task automatic report_failure(input string msg);
        err_other++;
        $display("Error: %s", msg);
    endtask

    function automatic void report_results();
        $display("errors: %0d value, %0d other", err_value, err_other);
        if (err_value + err_other == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
    endfunction

    // model update and output checks on the falling edge
    always @(negedge clk_i) begin : monitor
        logic task_req;
        logic gnt_exp;
        if (rst_ni) begin
            task_req = bus_req_i && (bus_addr_i[8:7] == REGION_TASK);
            gnt_exp  = task_req && running;
            assert (bus_gnt_o == gnt_exp) else report_mismatch("bus_gnt_o", bus_gnt_o, gnt_exp);
            assert (bus_rvalid_o == gnt_q)
                else report_mismatch("bus_rvalid_o", bus_rvalid_o, gnt_q);
            if (gnt_q) begin
                assert (bus_rdata_o == word_q)
                    else report_mismatch("bus_rdata_o", bus_rdata_o, word_q);
            end
            assert (hpu_active_o == init_done)
                else report_mismatch("hpu_active_o", hpu_active_o, init_done);
            assert (!(hpu_task_ready_o && running)) else report_failure("task ready while running");
            gnt_q  = gnt_exp;
            word_q = map_word(cur_task, bus_addr_i[7:0]);
            init_done = init_done || task_req;
            if (hpu_feedback_valid_o) begin
                assert (fb_queue.size() != 0) else report_failure("feedback with none expected");
                if (fb_queue.size() != 0) begin
                    assert (hpu_feedback_o == fb_queue[0])
                        else report_mismatch("hpu_feedback_o", hpu_feedback_o, fb_queue[0]);
                    if (hpu_feedback_ready_i) begin
                        void'(fb_queue.pop_front());
                    end
                end
                if (hpu_feedback_ready_i) begin
                    pops++;
                end
            end
            if (gnt_exp && bus_addr_i[7:0] == REG_FEEDBACK) begin
                fb_queue.push_back(expected_feedback(cur_task));
                running = 1'b0;
            end
            if (hpu_task_valid_i && hpu_task_ready_o) begin
                cur_task = hpu_task_i;
                if (hpu_task_i.handler_fun == '0) begin
                    fb_queue.push_back(expected_feedback(hpu_task_i));
                end else begin
                    running = 1'b1;
                end
            end
        end
    end

    task automatic step();
        @(posedge clk_i);
        #2;
        no_dma_req_pending_i = $random(seed);
        hpu_feedback_ready_i = $random(seed);
    endtask

    task automatic bus_access(input logic [1:0] region, input logic [7:0] off, input logic wen_n);
        bus_req_i   = 1'b1;
        bus_addr_i  = $random(seed);
        bus_addr_i[8:0] = {region, off[6:0]};
        bus_wen_ni  = wen_n;
        bus_wdata_i = $random(seed);
        step();
        bus_req_i = 1'b0;
    endtask

    function automatic logic [1:0] random_region();
        int rnd;
        rnd = $unsigned($random(seed)) % 8;
        return (rnd < 5) ? REGION_TASK : 2'(rnd - 4);
    endfunction

    task automatic drive_task(input hpu_task_t t);
        hpu_task_valid_i = 1'b1;
        hpu_task_i = t;
        // core keeps polling and none of it may be granted
        while (!hpu_task_ready_o) begin
            bus_access(random_region(), offsets[$unsigned($random(seed)) % 10], $random(seed));
        end
        // one more poll in the transfer cycle while task ready is high
        bus_access(random_region(), offsets[$unsigned($random(seed)) % 10], $random(seed));
        hpu_task_valid_i = 1'b0;
    endtask

    initial begin
        hpu_task_t t;
        int n;
        rst_ni = 1'b0;
        cluster_id_i = 6'h05;
        hpu_task_valid_i = 1'b0;
        hpu_task_i = '0;
        hpu_feedback_ready_i = 1'b0;
        no_dma_req_pending_i = 1'b1;
        bus_req_i = 1'b0;
        bus_addr_i = '0;
        bus_wen_ni = 1'b1;
        bus_wdata_i = '0;
        repeat (16) @(posedge clk_i);
        #2;
        rst_ni = 1'b1;
        assert (!hpu_active_o && !hpu_task_ready_o && !hpu_feedback_valid_o)
            else report_failure("outputs not idle after reset");
        // first task-region access brings the driver out of init
        bus_access(REGION_TASK, REG_PKT_PTR, 1'b1);
        assert (hpu_active_o && hpu_task_ready_o) else report_failure("driver did not leave init");
        for (int k = 0; k < NUM_TASKS; k++) begin
            t = {$random(seed), $random(seed), $random(seed), $random(seed), $random(seed),
                 10'($random(seed))};
            t.handler_fun = ($unsigned($random(seed)) % 5 == 0) ? '0 : (t.handler_fun | 32'h4);
            drive_task(t);
            if (t.handler_fun != '0) begin
                n = 1 + $unsigned($random(seed)) % 6;
                repeat (n) begin
                    bus_access(random_region(), offsets[$unsigned($random(seed)) % 10], 1'b1);
                end
                bus_access(REGION_TASK, REG_FEEDBACK, $random(seed));
            end
        end
        while (fb_queue.size() != 0 || !hpu_task_ready_o) begin
            step();
        end
        repeat (4) step();
        assert (pops == NUM_TASKS) else report_failure("not every task returned a descriptor");
        report_results();
        $finish;
    end

    initial begin
        wait (cycles >= MAX_CYCLES);
        report_failure("timeout, run did not finish in time");
        report_results();
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/feedback_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module feedback_buffer import hpu_pkg::*; (
    input  wire logic      clk_i,
    input  wire logic      rst_ni,

    input  wire logic      push_i,
    input  wire feedback_t data_i,
    input  wire logic      pop_i,

    output logic           full_o,
    output logic           empty_o,
    output feedback_t      data_o
);

    logic      occupied_q;
    feedback_t data_q;

    // single entry, so push and pop never meet in one cycle
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            occupied_q <= 1'b0;
        end else if (push_i && !occupied_q) begin
            occupied_q <= 1'b1;
        end else if (pop_i && occupied_q) begin
            occupied_q <= 1'b0;
        end
    end

    // payload held until popped
    always_ff @(posedge clk_i) begin
        if (push_i && !occupied_q) begin
            data_q <= data_i;
        end
    end

    assign full_o  = occupied_q;
    assign empty_o = !occupied_q;
    assign data_o  = data_q;

endmodule

`default_nettype wire

// File: verilog/hpu_driver.sv
`timescale 1ns/1ps
`default_nettype none

module hpu_driver import hpu_pkg::*; (
    input  wire logic              clk_i,
    input  wire logic              rst_ni,
    input  wire logic [5:0]        cluster_id_i,

    // task in
    input  wire logic              hpu_task_valid_i,
    output logic                   hpu_task_ready_o,
    input  wire hpu_task_t         hpu_task_i,

    // feedback out
    output logic                   hpu_feedback_valid_o,
    input  wire logic              hpu_feedback_ready_i,
    output feedback_t              hpu_feedback_o,

    output logic                   hpu_active_o,
    input  wire logic              no_dma_req_pending_i,

    // core peripheral bus
    input  wire logic              bus_req_i,
    input  wire logic [ADDR_W-1:0] bus_addr_i,
    input  wire logic              bus_wen_ni,
    input  wire logic [ADDR_W-1:0] bus_wdata_i,
    output logic                   bus_gnt_o,
    output logic                   bus_rvalid_o,
    output logic [ADDR_W-1:0]      bus_rdata_o
);

    periph_bus_if bus ();

    logic      capture;
    logic      fb_push;
    logic      fb_pop;
    logic      fb_full;
    logic      fb_empty;
    feedback_t fb_descr;

    assign bus.req   = bus_req_i;
    assign bus.addr  = bus_addr_i;
    assign bus.wen_n = bus_wen_ni;
    assign bus.wdata = bus_wdata_i;

    assign bus_gnt_o    = bus.gnt;
    assign bus_rvalid_o = bus.rvalid;
    assign bus_rdata_o  = bus.rdata;

    // descriptor leaves only while the core has no dma in flight
    assign hpu_feedback_valid_o = !fb_empty && no_dma_req_pending_i;
    assign fb_pop = hpu_feedback_valid_o && hpu_feedback_ready_i;

    hpu_ctrl i_hpu_ctrl (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .bus_i         (bus.driver),
        .task_valid_i  (hpu_task_valid_i),
        .task_ready_o  (hpu_task_ready_o),
        .handler_fun_i (hpu_task_i.handler_fun),
        .capture_o     (capture),
        .fb_full_i     (fb_full),
        .fb_push_o     (fb_push),
        .active_o      (hpu_active_o)
    );

    task_regs i_task_regs (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .bus_i      (bus.driver),
        .task_i     (hpu_task_i),
        .capture_i  (capture),
        .feedback_o (fb_descr)
    );

    feedback_buffer i_feedback_buffer (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .push_i  (fb_push),
        .data_i  (fb_descr),
        .pop_i   (fb_pop),
        .full_o  (fb_full),
        .empty_o (fb_empty),
        .data_o  (hpu_feedback_o)
    );

endmodule

`default_nettype wire

// File: verilog/task_regs.sv
`timescale 1ns/1ps
`default_nettype none

module task_regs import hpu_pkg::*; (
    input  wire logic      clk_i,
    input  wire logic      rst_ni,

    periph_bus_if.driver   bus_i,

    input  wire hpu_task_t task_i,
    input  wire logic      capture_i,

    output feedback_t      feedback_o
);

    hpu_task_t task_q;

    logic              rvalid_q;
    logic [ADDR_W-1:0] rdata_d, rdata_q;

    // current task, loaded on acceptance
    always_ff @(posedge clk_i) begin
        if (capture_i) begin
            task_q <= task_i;
        end
    end

    // register map
    always_comb begin
        rdata_d = '0;

        case (bus_i.addr[7:0])
            REG_HANDLER_FUN:  rdata_d = task_q.handler_fun;
            REG_HANDLER_MEM:  rdata_d = task_q.handler_mem;
            REG_PKT_PTR:      rdata_d = task_q.pkt_ptr;
            REG_PKT_SIZE:     rdata_d = task_q.pkt_size;
            REG_PKT_ADDR:     rdata_d = task_q.pkt_addr;
            REG_HOME_CLUSTER: rdata_d[CLUSTER_W-1:0] = task_q.msgid[CLUSTER_W-1:0];
            REG_MSGID:        rdata_d[MSGID_W-1:0] = task_q.msgid;
            // termination word and unmapped offsets read zero
            default:          rdata_d = '0;
        endcase
    end

    // response one cycle after the grant
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= bus_i.gnt;
        end
    end

    always_ff @(posedge clk_i) begin
        if (bus_i.gnt) begin
            rdata_q <= rdata_d;
        end
    end

    assign bus_i.rvalid = rvalid_q;
    assign bus_i.rdata  = rdata_q;

    // descriptor built from the held task
    assign feedback_o.pkt_ptr  = task_q.pkt_ptr;
    assign feedback_o.pkt_addr = task_q.pkt_addr;
    assign feedback_o.pkt_size = task_q.pkt_size;
    assign feedback_o.msgid    = task_q.msgid;

endmodule

`default_nettype wire

// File: vlog.f
common/hpu_pkg.sv
common/periph_bus_if.sv
hpu_ctrl/hpu_ctrl.sv
verilog/task_regs.sv
verilog/feedback_buffer.sv
verilog/hpu_driver.sv
sim/hpu_driver_sva.sv
sim/tb_hpu_driver.sv
